//--- fetch_subsystem.f
source/fetch_pkg.sv
source/fetch_icache.sv
source/fetch_unit.sv
source/fetch_perf_counters.sv
source/fetch_subsystem.sv
verif/fetch_subsystem_properties.sv
verif/fetch_subsystem_tb.sv

//--- source/fetch_icache.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_icache import fetch_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  cache_lookup_t lookup,
	input  logic          lookup_valid,
	input  cache_fill_t   fill,
	input  logic          fill_valid,
	output logic          hit,
	output logic [31:0]   data
);

	logic [22:0]           tag_mem  [line_count];
	logic [31:0]           data_mem [line_count * line_words];
	logic [line_count-1:0] line_valid;

	logic [3:0] lookup_index;
	logic [6:0] lookup_word;
	logic [3:0] fill_index;
	logic [6:0] fill_word;
	logic       fill_last;
	logic       tag_match;

	assign lookup_index = lookup.addr.f.index;
	assign lookup_word  = {lookup.addr.f.index, lookup.addr.f.offset};
	assign fill_index   = fill.addr.f.index;
	assign fill_word    = {fill.addr.f.index, fill.addr.f.offset};
	assign fill_last    = fill.addr.f.offset == 3'(line_words - 1);
	assign tag_match    = tag_mem[lookup_index] == lookup.addr.f.tag;

	////////////////////////////////////////
	// Valid bits and registered compare
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
			hit <= 1'b0;
		end else begin
			if (lookup_valid) begin
				hit <= line_valid[lookup_index] && tag_match;
			end
			if (fill_valid) begin
				line_valid[fill_index] <= fill_last; // Line is partial until its last word lands
			end
		end
	end

	////////////////////////////////////////
	// Tag and data arrays
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			tag_mem[fill_index] <= fill.addr.f.tag;
			data_mem[fill_word] <= fill.data;
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_valid) begin
			data <= data_mem[lookup_word]; // Read alongside the tag compare
		end
	end

endmodule

`default_nettype wire

//--- source/fetch_perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_perf_counters import fetch_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  fetch_events_t events,
	input  apb_req_t      apb_req,
	output apb_rsp_t      apb_rsp
);

	logic [31:0]              counters [counter_count];
	logic [counter_count-1:0] event_bits;
	logic                     access;
	logic                     clear;
	logic                     known;
	logic [31:0]              read_value;

	// Bit i feeds the counter at offset 4*i
	assign event_bits = {events.delivered, events.redirect, events.miss, events.hit, events.busy};
	assign access     = apb_req.psel && apb_req.penable;
	assign clear      = access && apb_req.pwrite;

	always_ff @(posedge clock) begin
		if (reset || clear) begin
			for (int i = 0; i < counter_count; i++) begin
				counters[i] <= 32'd0;
			end
		end else begin
			for (int i = 0; i < counter_count; i++) begin
				counters[i] <= counters[i] + 32'(event_bits[i]);
			end
		end
	end

	////////////////////////////////////////
	// Register read decode
	////////////////////////////////////////

	always_comb begin
		known = 1'b1;
		read_value = 32'd0;
		case (apb_req.paddr)
			reg_busy_offset:      read_value = counters[0];
			reg_hit_offset:       read_value = counters[1];
			reg_miss_offset:      read_value = counters[2];
			reg_redirect_offset:  read_value = counters[3];
			reg_delivered_offset: read_value = counters[4];
			default:              known = 1'b0;
		endcase
	end

	assign apb_rsp.prdata  = read_value;
	assign apb_rsp.pready  = 1'b1; // Zero wait states
	assign apb_rsp.pslverr = access && !apb_req.pwrite && !known;

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////
	// Address map and cache geometry
	////////////////////////////////////////

	localparam logic [31:0] reset_pc     = 32'h3000_0000;
	localparam logic [31:0] cached_base  = 32'ha000_0000;
	localparam logic [31:0] cached_limit = 32'ha200_0000;

	localparam int line_words    = 8; // One line is one burst
	localparam int line_count    = 16;
	localparam int counter_count = 5;

	localparam logic [3:0] burst_len   = 4'd7; // Beats minus one
	localparam logic [1:0] burst_fixed = 2'b00;
	localparam logic [1:0] burst_incr  = 2'b01;

	localparam logic [7:0] reg_busy_offset      = 8'h00;
	localparam logic [7:0] reg_hit_offset       = 8'h04;
	localparam logic [7:0] reg_miss_offset      = 8'h08;
	localparam logic [7:0] reg_redirect_offset  = 8'h0c;
	localparam logic [7:0] reg_delivered_offset = 8'h10;

	////////////////////////////////////////
	// Shared types
	////////////////////////////////////////

	typedef struct packed {
		logic [22:0] tag;
		logic [3:0]  index;
		logic [2:0]  offset;   // Word within the line
		logic [1:0]  byte_off;
	} fetch_fields_t;

	typedef union packed {
		logic [31:0]   word;
		fetch_fields_t f;
	} fetch_addr_u;

	typedef struct packed {
		logic [31:0] addr;
		logic [1:0]  burst;
		logic [3:0]  len;
	} mem_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
		logic        last;
	} mem_r_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fetch_out_t;

	typedef struct packed {
		fetch_addr_u addr;
	} cache_lookup_t;

	typedef struct packed {
		fetch_addr_u addr;
		logic [31:0] data;
	} cache_fill_t;

	typedef struct packed {
		logic busy;
		logic hit;
		logic miss;
		logic redirect;
		logic delivered;
	} fetch_events_t;

	typedef struct packed {
		logic [7:0]  paddr;
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

//--- source/fetch_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsystem import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	output mem_ar_t     ar,
	output logic        ar_valid,
	input  logic        ar_ready,
	input  mem_r_t      r,
	input  logic        r_valid,
	output logic        r_ready,
	input  logic        redirect_valid,
	input  logic [31:0] redirect_pc,
	output fetch_out_t  out,
	output logic        out_valid,
	input  logic        out_ready,
	input  apb_req_t    apb_req,
	output apb_rsp_t    apb_rsp
);

	cache_lookup_t lookup;
	logic          lookup_valid;
	logic          hit;
	logic [31:0]   cache_data;
	cache_fill_t   fill;
	logic          fill_valid;
	fetch_events_t events;

	fetch_unit i_fetch_unit (
		.clock(clock),
		.reset(reset),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.lookup(lookup),
		.lookup_valid(lookup_valid),
		.hit(hit),
		.cache_data(cache_data),
		.fill(fill),
		.fill_valid(fill_valid),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.out(out),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.events(events)
	);

	fetch_icache i_icache (
		.clock(clock),
		.reset(reset),
		.lookup(lookup),
		.lookup_valid(lookup_valid),
		.fill(fill),
		.fill_valid(fill_valid),
		.hit(hit),
		.data(cache_data)
	);

	fetch_perf_counters i_perf_counters (
		.clock(clock),
		.reset(reset),
		.events(events),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	output mem_ar_t       ar,
	output logic          ar_valid,
	input  logic          ar_ready,
	input  mem_r_t        r,
	input  logic          r_valid,
	output logic          r_ready,
	output cache_lookup_t lookup,
	output logic          lookup_valid,
	input  logic          hit,
	input  logic [31:0]   cache_data,
	output cache_fill_t   fill,
	output logic          fill_valid,
	input  logic          redirect_valid,
	input  logic [31:0]   redirect_pc,
	output fetch_out_t    out,
	output logic          out_valid,
	input  logic          out_ready,
	output fetch_events_t events
);

	typedef enum logic [1:0] {
		st_fetch,
		st_check,
		st_request,
		st_read
	} state_t;

	state_t      state;
	fetch_addr_u pc;
	logic [2:0]  beat;
	logic        redir_pending;
	logic [31:0] redir_target;

	logic        cacheable;
	logic        out_free;
	logic        discard;
	logic [31:0] next_target;
	logic [31:0] next_pc;
	logic        take_beat;
	logic        deliver;
	logic [31:0] deliver_data;

	assign cacheable    = (pc.word >= cached_base) && (pc.word < cached_limit);
	assign out_free     = !out_valid || out_ready;
	assign discard      = redirect_valid || redir_pending; // Current fetch is stale
	assign next_target  = redirect_valid ? redirect_pc : redir_target;
	assign next_pc      = discard ? next_target : pc.word + 32'd4;
	assign take_beat    = (state == st_read) && r_valid;
	assign deliver_data = (state == st_check) ? cache_data : r.data;

	// The pc word is handed over on its own beat, the rest of the line keeps filling
	assign deliver = !discard && (((state == st_check) && hit) ||
		(take_beat && (!cacheable || (beat == pc.f.offset))));

	////////////////////////////////////////
	// Memory, cache and decoder ports
	////////////////////////////////////////

	assign r_ready = 1'b1;

	always_comb begin
		if (cacheable) begin
			ar.addr  = {pc.f.tag, pc.f.index, 5'b0}; // Line aligned
			ar.burst = burst_incr;
			ar.len   = burst_len;
		end else begin
			ar.addr  = pc.word;
			ar.burst = burst_fixed;
			ar.len   = 4'd0;
		end
	end

	assign ar_valid     = state == st_request;
	assign lookup.addr  = pc;
	assign lookup_valid = (state == st_fetch) && cacheable && out_free;

	assign fill.addr.word = {pc.f.tag, pc.f.index, beat, 2'b00};
	assign fill.data      = r.data;
	assign fill_valid     = take_beat && cacheable;

	assign events.busy      = state != st_fetch;
	assign events.hit       = (state == st_check) && hit && !discard;
	assign events.miss      = (state == st_check) && !hit && !discard;
	assign events.redirect  = redirect_valid;
	assign events.delivered = out_valid && out_ready;

	////////////////////////////////////////
	// Fetch control
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_request; // Reset vector is uncached, so request at once
			pc.word <= reset_pc;
			beat <= 3'd0;
			redir_pending <= 1'b0;
		end else begin
			if (redirect_valid && (state != st_fetch)) begin
				redir_pending <= 1'b1;
				redir_target <= redirect_pc;
			end
			case (state)
				st_fetch: begin
					if (redirect_valid) begin
						pc.word <= redirect_pc; // Nothing in flight yet
					end else if (out_free) begin
						state <= cacheable ? st_check : st_request;
					end
				end
				st_check: begin
					if (discard || hit) begin
						pc.word <= next_pc;
						redir_pending <= 1'b0;
						state <= st_fetch;
					end else begin
						state <= st_request;
					end
				end
				st_request: begin
					if (ar_ready) begin
						beat <= 3'd0;
						state <= st_read;
					end
				end
				st_read: begin
					if (r_valid) begin
						beat <= beat + 3'd1;
						if (r.last) begin
							pc.word <= next_pc;
							redir_pending <= 1'b0;
							state <= st_fetch;
						end
					end
				end
				default: state <= st_fetch;
			endcase
		end
	end

	////////////////////////////////////////
	// Decoder output register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (deliver) begin
			out_valid <= 1'b1;
		end else if (redirect_valid || out_ready) begin
			out_valid <= 1'b0; // Accepted, or dropped by the redirect
		end
	end

	always_ff @(posedge clock) begin
		if (deliver) begin
			out.pc <= pc.word;
			out.inst <= deliver_data;
		end
	end

endmodule

`default_nettype wire

//--- verif/fetch_subsystem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsystem_properties import fetch_pkg::*; (
	input logic       clock,
	input logic       reset,
	input mem_ar_t    ar,
	input logic       ar_valid,
	input logic       ar_ready,
	input logic       r_ready,
	input logic       redirect_valid,
	input fetch_out_t out,
	input logic       out_valid,
	input logic       out_ready
);

	ar_holds: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else $error("Read request changed or dropped before it was accepted");

	// A redirect may drop a held output, so it is left out here
	out_holds: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !redirect_valid |=> out_valid && $stable(out))
		else $error("Decoder output changed or dropped before it was accepted");

	r_always_ready: assert property (@(posedge clock) disable iff (reset) r_ready)
		else $error("Read data channel was back-pressured");

endmodule

bind fetch_unit fetch_subsystem_properties i_properties (.*);

`default_nettype wire

//--- verif/fetch_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsystem_tb import fetch_pkg::*; ();

	localparam int watchdog_cycles = 4000;

	logic        clock = 1'b0;
	logic        reset;
	mem_ar_t     ar;
	logic        ar_valid;
	logic        ar_ready;
	mem_r_t      r;
	logic        r_valid;
	logic        r_ready;
	logic        redirect_valid;
	logic [31:0] redirect_pc;
	fetch_out_t  out;
	logic        out_valid;
	logic        out_ready;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;

	logic [31:0] lfsr = 32'h0bd72332;
	logic        hold_out;
	logic        mem_active;
	logic [31:0] mem_addr;
	int          mem_left;
	logic        mem_incr;
	logic        stale_req;
	logic [31:0] exp_pc;
	int          accepted;
	int          accepted_cached;
	int          bursts;
	int          redirects;
	int          value_errors;
	int          other_errors;
	bit          seen_line [logic [31:0]];

	fetch_subsystem i_dut (.*);

	always #4 clock = ~clock;

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return addr ^ 32'h5a5a_0000;
	endfunction

	function automatic logic in_cached(input logic [31:0] addr);
		return (addr >= cached_base) && (addr < cached_limit);
	endfunction

	function logic random_bit();
		random_bit = lfsr[0];
		lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0); // Galois step
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected, actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	////////////////////////////////////////
	// Memory responder and decoder sink
	////////////////////////////////////////

	always @(negedge clock) begin
		ar_ready = random_bit();
		out_ready = hold_out ? 1'b0 : (random_bit() | random_bit());
		r_valid = mem_active && random_bit(); // Random gaps between beats
		r.data = mem_word(mem_addr);
		r.resp = 2'b00;
		r.last = mem_left == 1;
	end

	always @(posedge clock) begin
		if (reset) begin
			mem_active = 1'b0;
			mem_addr = 32'd0;
			mem_left = 0;
			stale_req = 1'b0;
			exp_pc = reset_pc;
		end else begin
			if (r_valid && r_ready) begin
				mem_left--;
				mem_addr = mem_incr ? mem_addr + 32'd4 : mem_addr;
				mem_active = mem_left != 0;
			end
			if (ar_valid && ar_ready) begin
				if (in_cached(ar.addr)) begin
					check_value("burst len", 32'd7, 32'(ar.len));
					check_value("burst type", 32'(burst_incr), 32'(ar.burst));
					if (!stale_req && !redirect_valid) begin
						check_value("burst addr", {exp_pc[31:5], 5'd0}, ar.addr);
					end
					if (seen_line.exists(ar.addr)) begin
						other_errors++;
						$display("Line at %h was requested again after it was filled", ar.addr);
					end
					seen_line[ar.addr] = 1'b1;
					bursts++;
				end else begin
					check_value("single len", 32'd0, 32'(ar.len));
					check_value("single type", 32'(burst_fixed), 32'(ar.burst));
					if (!stale_req && !redirect_valid) begin
						check_value("single addr", exp_pc, ar.addr);
					end
				end
				stale_req = 1'b0;
				mem_active = 1'b1;
				mem_addr = ar.addr;
				mem_left = int'(ar.len) + 1;
				mem_incr = ar.burst == burst_incr;
			end
			if (out_valid && out_ready) begin
				accepted++;
				accepted_cached += in_cached(out.pc) ? 1 : 0;
				exp_pc = exp_pc + 32'd4;
			end
			if (redirect_valid) begin
				redirects++;
				stale_req = stale_req || (ar_valid && !ar_ready); // Held request is for the old path
				exp_pc = redirect_pc; // Next accepted pc follows the redirect
			end
		end
	end

	////////////////////////////////////////
	// Checking assertions
	////////////////////////////////////////

	assert property (@(posedge clock) disable iff (reset)
		out_valid && out_ready |-> out.pc == exp_pc)
		else begin
			value_errors++;
			$display("[FAIL] delivered pc: expected %h, actual %h",
				$sampled(exp_pc), $sampled(out.pc));
		end

	assert property (@(posedge clock) disable iff (reset)
		out_valid && out_ready |-> out.inst == mem_word(out.pc))
		else begin
			value_errors++;
			$display("[FAIL] delivered inst: expected %h, actual %h",
				mem_word($sampled(out.pc)), $sampled(out.inst));
		end

	assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !redirect_valid |=> out_valid && $stable(out))
		else begin
			other_errors++;
			$display("Held output changed before the decoder accepted it");
		end

	assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |-> !(ar_valid && ar_ready))
		else begin
			other_errors++;
			$display("A read request was accepted under decoder back-pressure");
		end

	assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			other_errors++;
			$display("Read request changed before it was accepted");
		end

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic run_accepts(input int count);
		int target;
		target = accepted + count;
		while (accepted < target) @(negedge clock);
	endtask

	task automatic redirect_to(input logic [31:0] target);
		@(negedge clock);
		redirect_valid = 1'b1;
		redirect_pc = target;
		@(negedge clock);
		redirect_valid = 1'b0;
	endtask

	task automatic quiesce();
		@(posedge clock);
		hold_out = 1'b1;
		do @(negedge clock); while (!(out_valid && !out_ready && !i_dut.events.busy));
	endtask

	task automatic apb_access(input logic [7:0] addr, input logic write,
			output logic [31:0] data, output logic err);
		@(negedge clock);
		apb_req.paddr = addr;
		apb_req.pwrite = write;
		apb_req.pwdata = 32'd0;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		@(negedge clock);
		apb_req.penable = 1'b1;
		#2;
		data = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		check_value("pready", 32'd1, 32'(apb_rsp.pready));
		@(negedge clock);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic check_counter(input string name, input logic [7:0] addr, input int expected);
		logic [31:0] data;
		logic        err;
		apb_access(addr, 1'b0, data, err);
		check_value(name, 32'(expected), data);
		check_value("known offset pslverr", 32'd0, 32'(err));
	endtask

	initial begin
		logic [31:0] data;
		logic        err;
		logic [31:0] hits;
		logic [31:0] misses;
		int          base_accepted;
		int          base_cached;
		int          base_bursts;
		reset = 1'b1;
		hold_out = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = 32'd0;
		apb_req = '0;
		ar_ready = 1'b0;
		r = '0;
		r_valid = 1'b0;
		out_ready = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		run_accepts(40); // Uncached run from the reset vector
		redirect_to(32'ha000_0000);
		run_accepts(80);
		redirect_to(32'ha000_0010); // Back into filled lines
		run_accepts(60);
		redirect_to(32'h3000_0100);
		run_accepts(20);
		redirect_to(32'ha000_0100);
		run_accepts(40);
		quiesce();
		check_counter("delivered count", reg_delivered_offset, accepted);
		check_counter("redirect count", reg_redirect_offset, redirects);

		apb_access(8'h00, 1'b1, data, err);
		base_accepted = accepted;
		base_cached = accepted_cached + (in_cached(out.pc) ? 1 : 0); // Held word was looked up before the clear
		base_bursts = bursts;
		for (int i = 0; i < 5; i++) begin
			check_counter("cleared counter", 8'(4 * i), 0);
		end
		apb_access(8'h20, 1'b0, data, err);
		check_value("pslverr", 32'd1, 32'(err));

		@(posedge clock);
		hold_out = 1'b0;
		run_accepts(30);
		quiesce();
		apb_access(reg_hit_offset, 1'b0, hits, err);
		apb_access(reg_miss_offset, 1'b0, misses, err);
		check_value("miss count", 32'(bursts - base_bursts), misses);
		check_value("hit plus miss",
			32'(accepted_cached - base_cached + (in_cached(out.pc) ? 1 : 0)), hits + misses);
		check_counter("delivered count", reg_delivered_offset, accepted - base_accepted);

		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
